/* filelist.f */
+incdir+include
source/conv_pkg.sv
source/window_feeder.sv
source/mac_unit.sv
source/tile_drain.sv
source/conv_tile_top.sv
tb/conv_tile_model.sv
tb/conv_tile_tb.sv

/* include/conv_defines.svh */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// output tile is PARA_X rows by PARA_Y columns
`define PARA_X 3
`define PARA_Y 3

// Q8.8 elements, wide accumulator
`define DATA_WIDTH 16
`define ACC_WIDTH 32
`define FRAC_BITS 8

// largest supported kernel edge
`define KERNEL_MAX 5

// one register group covers a tile row plus the kernel overhang
`define ROW_LEN (`PARA_Y + `KERNEL_MAX - 1)

// kernel size and beat counters, wide enough for long fc jobs
`define COUNT_WIDTH 5

`endif

/* source/conv_pkg.sv */
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

	// one MAC lane per output of the tile
	localparam int LANES = `PARA_X * `PARA_Y;

	typedef logic signed [`DATA_WIDTH-1:0] elem_t;

	typedef enum logic {
		OP_CONV = 1'b0,
		OP_FC   = 1'b1
	} op_e;

	// codes other than relu behave as none
	typedef enum logic [1:0] {
		ACT_NONE = 2'd0,
		ACT_RELU = 2'd1
	} act_e;

	// fc jobs carry one weight per neuron in the low elements
	typedef struct packed {
		elem_t [`PARA_X*`ROW_LEN-`PARA_Y-1:0] pad;
		elem_t [`PARA_Y-1:0]                  weight;
	} fc_beat_t;

	// conv view has row 0 in the low bits
	typedef union packed {
		elem_t [`PARA_X-1:0][`ROW_LEN-1:0] conv;
		fc_beat_t                          fc;
	} beat_u;

endpackage

`default_nettype wire

/* source/conv_tile_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module conv_tile_top import conv_pkg::*; (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire beat_u             in_beat,
	input  wire elem_t             in_weight,
	input  wire op_e               op_type,
	input  wire [`COUNT_WIDTH-1:0] kernel_size,
	input  wire act_e              activation,
	output logic                   out_valid,
	input  wire                    out_ready,
	output elem_t                  out_tile [LANES]
);

	elem_t                        a_op [LANES];
	elem_t                        b_op;
	logic                         mac_start;
	logic                         mac_last;
	op_e                          job_op;
	act_e                         job_act;
	logic signed [`ACC_WIDTH-1:0] acc [LANES];
	logic [LANES-1:0]             acc_valid;
	logic                         stall;

	window_feeder window_feeder_i (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_beat     (in_beat),
		.in_weight   (in_weight),
		.op_type     (op_type),
		.kernel_size (kernel_size),
		.activation  (activation),
		.stall       (stall),
		.a_op        (a_op),
		.b_op        (b_op),
		.mac_start   (mac_start),
		.mac_last    (mac_last),
		.job_op      (job_op),
		.job_act     (job_act)
	);

	// one lane per tile output, all sharing the weight
	for (genvar lane = 0; lane < LANES; lane++) begin : g_mac
		mac_unit mac_unit_i (
			.clk       (clk),
			.rst       (rst),
			.a         (a_op[lane]),
			.b         (b_op),
			.start     (mac_start),
			.last      (mac_last),
			.acc       (acc[lane]),
			.acc_valid (acc_valid[lane])
		);
	end

	tile_drain tile_drain_i (
		.clk       (clk),
		.rst       (rst),
		.acc       (acc),
		.acc_valid (acc_valid),
		.job_op    (job_op),
		.job_act   (job_act),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_tile  (out_tile),
		.stall     (stall)
	);

endmodule

`default_nettype wire

/* source/mac_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module mac_unit import conv_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire elem_t                   a,
	input  wire elem_t                   b,
	input  wire                          start,
	input  wire                          last,
	output logic signed [`ACC_WIDTH-1:0] acc,
	output logic                         acc_valid
);

	// full Q16.16 product
	logic signed [2*`DATA_WIDTH-1:0] prod;
	logic                            start_q;
	logic                            last_q;

	always_ff @(posedge clk) begin
		prod <= a * b;
	end

	// strobes follow the product stage
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			start_q   <= 1'b0;
			last_q    <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			start_q   <= start;
			last_q    <= last;
			acc_valid <= last_q;
		end
	end

	// first product of a job replaces the old sum
	always_ff @(posedge clk) begin
		if (start_q) begin
			acc <= `ACC_WIDTH'(prod);
		end else begin
			acc <= acc + `ACC_WIDTH'(prod);
		end
	end

endmodule

`default_nettype wire

/* source/tile_drain.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module tile_drain import conv_pkg::*; (
	input  wire                         clk,
	input  wire                         rst,
	input  wire signed [`ACC_WIDTH-1:0] acc [LANES],
	input  wire [LANES-1:0]             acc_valid,
	input  wire op_e                    job_op,
	input  wire act_e                   job_act,
	output logic                        out_valid,
	input  wire                         out_ready,
	output elem_t                       out_tile [LANES],
	output logic                        stall
);

	// signed range of one element
	localparam logic signed [`ACC_WIDTH-1:0] SAT_MAX = 2**(`DATA_WIDTH-1) - 1;
	localparam logic signed [`ACC_WIDTH-1:0] SAT_MIN = -(2**(`DATA_WIDTH-1));

	logic relu_on;

	// back to Q8.8, clamp, then optional relu
	function automatic elem_t shape(input logic signed [`ACC_WIDTH-1:0] value,
		input logic relu);
		logic signed [`ACC_WIDTH-1:0] scaled;
		elem_t                        result;
		scaled = value >>> `FRAC_BITS;
		if (scaled > SAT_MAX) begin
			result = elem_t'(SAT_MAX);
		end else if (scaled < SAT_MIN) begin
			result = elem_t'(SAT_MIN);
		end else begin
			result = elem_t'(scaled);
		end
		if (relu && result < 0) begin
			result = '0;
		end
		return result;
	endfunction

	assign relu_on = (job_act == ACT_RELU);

	// all lanes finish together, lane 0 speaks for the array
	always_ff @(posedge clk) begin
		if (acc_valid[0]) begin
			for (int x = 0; x < `PARA_X; x++) begin
				for (int y = 0; y < `PARA_Y; y++) begin
					// fc only fills the first row of the tile
					if (job_op == OP_FC && x > 0) begin
						out_tile[x*`PARA_Y + y] <= '0;
					end else begin
						out_tile[x*`PARA_Y + y] <= shape(acc[x*`PARA_Y + y], relu_on);
					end
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else if (acc_valid[0]) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// also hold off while a sum is arriving, so the next job cannot
	// finish into a tile that is still waiting
	assign stall = (out_valid && !out_ready) || acc_valid[0];

	// the nine lanes are fed the same strobes
	a_lanes_agree: assert property (@(posedge clk) disable iff (!rst)
		acc_valid == '0 || acc_valid == '1);

	// the feeder stall must keep a new sum away from a held tile
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst)
		out_valid && !out_ready |-> acc_valid == '0);

endmodule

`default_nettype wire

/* source/window_feeder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module window_feeder import conv_pkg::*; (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire beat_u             in_beat,
	input  wire elem_t             in_weight,
	input  wire op_e               op_type,
	input  wire [`COUNT_WIDTH-1:0] kernel_size,
	input  wire act_e              activation,
	input  wire                    stall,
	output elem_t                  a_op [LANES],
	output elem_t                  b_op,
	output logic                   mac_start,
	output logic                   mac_last,
	output op_e                    job_op,
	output act_e                   job_act
);

	// settings of the job in flight
	op_e                     cur_op;
	act_e                    cur_act;
	logic [`COUNT_WIDTH-1:0] cur_ks;

	// kernel column and row of the next beat, fc uses only the column
	logic [`COUNT_WIDTH-1:0] col_cnt;
	logic [`COUNT_WIDTH-1:0] row_cnt;

	// one register group per output row
	elem_t [`ROW_LEN-1:0] rows [`PARA_X];

	logic                    accept;
	logic                    first;
	op_e                     eff_op;
	act_e                    eff_act;
	logic [`COUNT_WIDTH-1:0] eff_ks;
	logic                    col_end;
	logic                    last;

	assign in_ready = !stall;
	assign accept   = in_valid && in_ready;
	assign first    = (col_cnt == '0) && (row_cnt == '0);

	// first beat brings the settings, later beats use the held copy
	assign eff_op  = first ? op_type : cur_op;
	assign eff_act = first ? activation : cur_act;
	assign eff_ks  = first ? kernel_size : cur_ks;

	assign col_end = (col_cnt == eff_ks - 1'b1);
	assign last    = col_end && (eff_op == OP_FC || row_cnt == eff_ks - 1'b1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cur_op  <= OP_CONV;
			cur_act <= ACT_NONE;
			cur_ks  <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (accept) begin
			cur_op  <= eff_op;
			cur_act <= eff_act;
			cur_ks  <= eff_ks;
			if (last) begin
				col_cnt <= '0;
				row_cnt <= '0;
			end else if (col_end) begin
				// next kernel row of a conv job
				col_cnt <= '0;
				row_cnt <= row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// lane strobes and the shared operand
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			b_op      <= '0;
			mac_start <= 1'b0;
			mac_last  <= 1'b0;
			job_op    <= OP_CONV;
			job_act   <= ACT_NONE;
		end else begin
			// idle cycles feed a zero weight, so the lanes add nothing
			b_op      <= accept ? in_weight : elem_t'(0);
			mac_start <= accept && first;
			mac_last  <= accept && last;
			if (accept && last) begin
				job_op  <= eff_op;
				job_act <= eff_act;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int x = 0; x < `PARA_X; x++) begin
				if (eff_op == OP_FC) begin
					// neuron weights go to lanes 0..2, the other rows stay silent
					if (x == 0) begin
						rows[x] <= {{(`ROW_LEN-`PARA_Y)*`DATA_WIDTH{1'b0}},
							in_beat.fc.weight};
					end else begin
						rows[x] <= '0;
					end
				end else if (col_cnt == '0) begin
					rows[x] <= in_beat.conv[x];
				end else begin
					// slide the window one element toward index 0
					rows[x] <= {elem_t'(0), rows[x][`ROW_LEN-1:1]};
				end
			end
		end
	end

	// lane (x,y) reads element y of row group x
	for (genvar x = 0; x < `PARA_X; x++) begin : g_row
		for (genvar y = 0; y < `PARA_Y; y++) begin : g_col
			assign a_op[x*`PARA_Y + y] = rows[x][y];
		end
	end

	// the register groups are only built for these two kernels
	a_conv_kernel: assert property (@(posedge clk) disable iff (!rst)
		accept && first && op_type == OP_CONV |-> kernel_size == 3 || kernel_size == 5);

endmodule

`default_nettype wire

/* tb/conv_tile_model.sv */
`default_nettype none

`include "conv_defines.svh"

package conv_tile_model;

	import conv_pkg::*;

	// longest fc job the testbench draws
	localparam int FC_MAX   = 20;
	localparam int IMG_ROWS = `PARA_X + `KERNEL_MAX - 1;

	typedef elem_t img_t [IMG_ROWS][`ROW_LEN];
	typedef elem_t kernel_t [`KERNEL_MAX][`KERNEL_MAX];
	typedef elem_t fc_w_t [FC_MAX][`PARA_Y];
	typedef elem_t fc_x_t [FC_MAX];
	typedef elem_t tile_t [LANES];

	// drop the fraction bits, clamp to the element range, zero negatives under relu
	function automatic elem_t saturate_relu(input int sum, input bit relu);
		int scaled;
		int top;
		top    = (1 << (`DATA_WIDTH - 1)) - 1;
		scaled = sum >>> `FRAC_BITS;
		if (scaled > top) begin
			scaled = top;
		end else if (scaled < -top - 1) begin
			scaled = -top - 1;
		end
		if (relu && scaled < 0) begin
			scaled = 0;
		end
		return elem_t'(scaled);
	endfunction

	// o[x][y] = sum over the kernel of w[i][j] * in[x+i][y+j], 32-bit wrapping sum
	function automatic tile_t conv_tile(input img_t img, input kernel_t w, input int ks,
		input bit relu);
		tile_t tile;
		int    sum;
		for (int x = 0; x < `PARA_X; x++) begin
			for (int y = 0; y < `PARA_Y; y++) begin
				sum = 0;
				for (int i = 0; i < ks; i++) begin
					for (int j = 0; j < ks; j++) begin
						sum += int'(w[i][j]) * int'(img[x+i][y+j]);
					end
				end
				tile[x*`PARA_Y + y] = saturate_relu(sum, relu);
			end
		end
		return tile;
	endfunction

	// three neurons in lanes 0..2, the rest of the tile stays zero
	function automatic tile_t fc_tile(input fc_w_t fw, input fc_x_t fx, input int len,
		input bit relu);
		tile_t tile;
		int    sum;
		for (int lane = 0; lane < LANES; lane++) begin
			tile[lane] = '0;
		end
		for (int n = 0; n < `PARA_Y; n++) begin
			sum = 0;
			for (int k = 0; k < len; k++) begin
				sum += int'(fw[k][n]) * int'(fx[k]);
			end
			tile[n] = saturate_relu(sum, relu);
		end
		return tile;
	endfunction

endpackage

`default_nettype wire

/* tb/conv_tile_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_defines.svh"

module conv_tile_tb import conv_pkg::*, conv_tile_model::*; ();

	localparam int NUM_JOBS   = 240;
	localparam int SEED       = 32'h36dc;
	// every job bounded by a full 5x5 job plus the pipeline and a margin of four
	localparam int TIMEOUT_NS = NUM_JOBS * (`KERNEL_MAX * `KERNEL_MAX + 3) * 8 * 4;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    in_valid;
	logic                    in_ready;
	beat_u                   in_beat;
	elem_t                   in_weight;
	op_e                     op_type;
	logic [`COUNT_WIDTH-1:0] kernel_size;
	act_e                    activation;
	logic                    out_valid;
	logic                    out_ready;
	elem_t                   out_tile [LANES];

	// expected lanes of every outstanding job in job order
	elem_t exp_q [$];
	// clock edge of each job's last accepted beat
	int    last_edge_q [$];
	int    cycle = 0;
	int    gap_pct = 0;
	int    ready_pct = 100;
	bit    pending = 1'b0;
	int    rise_count = 0;
	int    done_count = 0;

	conv_tile_top conv_tile_top_i (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_beat     (in_beat),
		.in_weight   (in_weight),
		.op_type     (op_type),
		.kernel_size (kernel_size),
		.activation  (activation),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_tile    (out_tile)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %0d actual %0d", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// small values near one or large ones that drive the output into saturation
	function automatic elem_t rand_elem(input bit big);
		if (big) begin
			return elem_t'(int'($urandom_range(0, 4094)) - 2047);
		end
		return elem_t'(int'($urandom_range(0, 512)) - 256);
	endfunction

	function automatic beat_u random_beat();
		beat_u beat;
		for (int x = 0; x < `PARA_X; x++) begin
			for (int k = 0; k < `ROW_LEN; k++) begin
				beat.conv[x][k] = elem_t'($urandom);
			end
		end
		return beat;
	endfunction

	// called after a falling edge and returns after the next one
	task automatic send_beat(input beat_u beat, input elem_t weight, input bit first,
		input op_e op, input logic [`COUNT_WIDTH-1:0] ks, input act_e act,
		output int edge_idx);
		if ($urandom_range(0, 99) < gap_pct) begin
			repeat ($urandom_range(1, 3)) @(negedge clk);
		end
		in_valid  = 1'b1;
		in_beat   = beat;
		in_weight = weight;
		// job settings only count on the first beat
		op_type     = first ? op : op_e'($urandom_range(0, 1));
		kernel_size = first ? ks : `COUNT_WIDTH'($urandom_range(0, 31));
		activation  = first ? act : act_e'($urandom_range(0, 3));
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
		edge_idx = cycle;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic run_job();
		img_t                    img;
		kernel_t                 w;
		fc_w_t                   fw;
		fc_x_t                   fx;
		tile_t                   expected;
		beat_u                   beat;
		op_e                     op;
		act_e                    act;
		logic [`COUNT_WIDTH-1:0] ks;
		bit                      big;
		int                      accepted;
		big = ($urandom_range(0, 3) == 0);
		op  = op_e'($urandom_range(0, 1));
		act = act_e'($urandom_range(0, 3));
		if (op == OP_CONV) begin
			ks = $urandom_range(0, 1) ? `COUNT_WIDTH'(5) : `COUNT_WIDTH'(3);
			foreach (img[r, k]) begin
				img[r][k] = rand_elem(big);
			end
			foreach (w[i, j]) begin
				w[i][j] = rand_elem(big);
			end
			expected = conv_tile(img, w, ks, act == ACT_RELU);
		end else begin
			ks = `COUNT_WIDTH'($urandom_range(3, FC_MAX));
			for (int k = 0; k < FC_MAX; k++) begin
				fx[k] = rand_elem(big);
				for (int n = 0; n < `PARA_Y; n++) begin
					fw[k][n] = rand_elem(big);
				end
			end
			expected = fc_tile(fw, fx, ks, act == ACT_RELU);
		end
		for (int lane = 0; lane < LANES; lane++) begin
			exp_q.push_back(expected[lane]);
		end
		if (op == OP_CONV) begin
			for (int i = 0; i < ks; i++) begin
				for (int j = 0; j < ks; j++) begin
					beat = random_beat();
					// row start carries input rows x+i while other beats carry junk
					if (j == 0) begin
						for (int x = 0; x < `PARA_X; x++) begin
							for (int k = 0; k < `ROW_LEN; k++) begin
								beat.conv[x][k] = img[x+i][k];
							end
						end
					end
					send_beat(beat, w[i][j], i == 0 && j == 0, op, ks, act, accepted);
				end
			end
		end else begin
			for (int k = 0; k < ks; k++) begin
				beat = random_beat();
				for (int n = 0; n < `PARA_Y; n++) begin
					beat.fc.weight[n] = fw[k][n];
				end
				send_beat(beat, fx[k], k == 0, op, ks, act, accepted);
			end
		end
		last_edge_q.push_back(accepted);
	endtask

	task automatic drive_out_ready();
		forever begin
			@(negedge clk);
			out_ready = ($urandom_range(0, 99) < ready_pct);
		end
	endtask

	// sampled on the rising edge before the DUT registers update
	always @(posedge clk) begin
		if (rst) begin
			if (out_valid && !out_ready) begin
				check_value("in_ready while result held", 0, in_ready);
			end
			if (out_valid && !pending) begin
				// the result appeared at the previous edge
				if (last_edge_q.size() == 0) begin
					abort_run("out_valid rose with no finished job");
				end else begin
					check_value($sformatf("latency of result %0d", rise_count),
						last_edge_q.pop_front() + 3, cycle - 1);
				end
				rise_count++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() < LANES) begin
					abort_run("result taken with no job outstanding");
				end else begin
					for (int lane = 0; lane < LANES; lane++) begin
						check_value($sformatf("result %0d lane %0d", done_count, lane),
							exp_q.pop_front(), out_tile[lane]);
					end
				end
				done_count++;
			end
			pending = out_valid && !out_ready;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("timeout, jobs did not complete in time");
	end

	initial begin
		void'($urandom(SEED));
		rst         = 1'b0;
		in_valid    = 1'b0;
		in_beat     = '0;
		in_weight   = '0;
		op_type     = OP_CONV;
		kernel_size = `COUNT_WIDTH'(3);
		activation  = ACT_NONE;
		out_ready   = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		check_value("out_valid after reset", 0, out_valid);
		check_value("in_ready after reset", 1, in_ready);
		fork
			drive_out_ready();
		join_none
		// first third plain, then input gaps, then output stalls on top
		for (int job = 0; job < NUM_JOBS; job++) begin
			if (job == NUM_JOBS / 3) begin
				gap_pct = 25;
			end
			if (job == 2 * NUM_JOBS / 3) begin
				ready_pct = 70;
			end
			run_job();
		end
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		// a few idle cycles in which a stray extra result would still show up
		repeat (8) @(negedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
